//--- verilog/cgra_conf_pkg.sv
`default_nettype none

package cgra_conf_pkg;

  // ------------------------------------------------------------------
  // Memory line and header layout.
  // ------------------------------------------------------------------
  localparam int LINE_W = 512;
  localparam int QTD_W = 32;

  localparam int HDR_PE_QTD_LSB = 0;
  localparam int HDR_NET_QTD_LSB = 32;
  localparam int HDR_RD_MASK_LSB = 64;
  localparam int HDR_WR_MASK_LSB = 96;

  // ------------------------------------------------------------------
  // Configuration words.
  // ------------------------------------------------------------------
  localparam int PE_WORDS_PER_LINE = 8;
  localparam int NET_WORDS_PER_LINE = 16;
  localparam int PE_SLOT_W = LINE_W / PE_WORDS_PER_LINE;
  localparam int NET_SLOT_W = LINE_W / NET_WORDS_PER_LINE;

  // Bit positions inside one 64-bit PE slot.
  localparam int PE_OP_LSB = 0;
  localparam int PE_DATA_HI_LSB = 8;
  localparam int PE_ID_LSB = 16;
  localparam int PE_DATA_LO_LSB = 32;

  typedef struct packed {
    logic [39:0] data;
    logic [15:0] id;
    logic [3:0]  op;
  } pe_conf_word_t;

  typedef struct packed {
    logic [15:0] route;      // High half of the slot.
    logic [15:0] switch_id;  // Low half of the slot.
  } net_conf_word_t;

  typedef enum logic [0:0] {
    SEL_PE  = 1'b0,
    SEL_NET = 1'b1
  } conf_sel_t;

  localparam int CONF_PAYLOAD_W = 60;

endpackage

`default_nettype wire

//--- verilog/conf_word_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module conf_word_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int DEPTH = 4
) (
  input  wire           clk,
  input  wire           rst,
  input  wire           push,
  input  wire payload_t push_data,
  output logic          full,
  input  wire           pop,
  output payload_t      pop_data,
  output logic          empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wrap at DEPTH so any depth works, not only powers of two.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign pop_data = mem[rd_ptr];  // Head is visible before the pop.

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // The producer must honour full, the consumer must honour empty.
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) full |-> !push);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

`default_nettype wire

//--- verilog/pe_conf_control.sv
`timescale 1ns/1ns
`default_nettype none

module pe_conf_control (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                start,
  input  wire                                pe_available_read,
  output logic                               pe_req_rd_data,
  input  wire [cgra_conf_pkg::LINE_W-1:0]    pe_rd_data,
  input  wire                                pe_rd_data_valid,
  output logic                               push,
  output cgra_conf_pkg::pe_conf_word_t       word,
  input  wire                                full,
  output logic [cgra_conf_pkg::QTD_W-1:0]    qtd_net_conf,
  output logic                               net_start,
  output logic [1:0]                         read_fifo_mask,
  output logic [1:0]                         write_fifo_mask,
  output logic                               done
);

  localparam int SLOT_CNT_W = $clog2(cgra_conf_pkg::PE_WORDS_PER_LINE);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA,
    ST_HEADER,
    ST_SEND,
    ST_DONE
  } state_t;

  state_t state;
  logic header_seen;
  logic [cgra_conf_pkg::LINE_W-1:0] line;
  logic [cgra_conf_pkg::QTD_W-1:0] qtd_pe_conf;
  logic [cgra_conf_pkg::QTD_W-1:0] sent_cnt;
  logic [SLOT_CNT_W-1:0] slot_cnt;
  logic last_slot;
  logic last_word;

  // ------------------------------------------------------------------
  // Handshake and word extraction.
  // ------------------------------------------------------------------
  assign pe_req_rd_data = (state == ST_REQUEST) && pe_available_read;
  assign push = (state == ST_SEND) && !full;
  assign done = (state == ST_DONE);

  assign last_slot = (slot_cnt == SLOT_CNT_W'(cgra_conf_pkg::PE_WORDS_PER_LINE - 1));
  assign last_word = (sent_cnt == qtd_pe_conf - 1'b1);

  // Lowest 64-bit slot of the line holds the current word.
  always_comb begin
    word.op = line[cgra_conf_pkg::PE_OP_LSB +: 4];
    word.id = line[cgra_conf_pkg::PE_ID_LSB +: 16];
    word.data = {line[cgra_conf_pkg::PE_DATA_HI_LSB +: 8],
                 line[cgra_conf_pkg::PE_DATA_LO_LSB +: 32]};
  end

  // ------------------------------------------------------------------
  // Control FSM.
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      header_seen <= 1'b0;
      net_start <= 1'b0;
      qtd_pe_conf <= '0;
      qtd_net_conf <= '0;
      read_fifo_mask <= '0;
      write_fifo_mask <= '0;
      sent_cnt <= '0;
      slot_cnt <= '0;
    end else begin
      net_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            header_seen <= 1'b0;
            state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (pe_available_read) begin
            state <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA: begin
          if (pe_rd_data_valid) begin
            line <= pe_rd_data;
            slot_cnt <= '0;
            state <= header_seen ? ST_SEND : ST_HEADER;
          end
        end
        ST_HEADER: begin
          qtd_pe_conf <= line[cgra_conf_pkg::HDR_PE_QTD_LSB +: cgra_conf_pkg::QTD_W];
          qtd_net_conf <= line[cgra_conf_pkg::HDR_NET_QTD_LSB +: cgra_conf_pkg::QTD_W];
          read_fifo_mask <= line[cgra_conf_pkg::HDR_RD_MASK_LSB +: 2];
          write_fifo_mask <= line[cgra_conf_pkg::HDR_WR_MASK_LSB +: 2];
          header_seen <= 1'b1;
          net_start <= 1'b1;  // Network side starts with the count.
          sent_cnt <= '0;
          if (line[cgra_conf_pkg::HDR_PE_QTD_LSB +: cgra_conf_pkg::QTD_W] == '0) begin
            state <= ST_DONE;
          end else begin
            state <= ST_REQUEST;
          end
        end
        ST_SEND: begin
          if (!full) begin
            line <= line >> cgra_conf_pkg::PE_SLOT_W;
            sent_cnt <= sent_cnt + 1'b1;
            slot_cnt <= slot_cnt + 1'b1;
            if (last_word) begin
              state <= ST_DONE;
            end else if (last_slot) begin
              state <= ST_REQUEST;  // Line used up.
            end
          end
        end
        ST_DONE: begin
          state <= ST_DONE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Memory answers only the one request that is outstanding.
  a_valid_when_waiting: assert property (@(posedge clk) disable iff (rst)
    pe_rd_data_valid |-> (state == ST_WAIT_DATA));

endmodule

`default_nettype wire

//--- verilog/net_conf_control.sv
`timescale 1ns/1ns
`default_nettype none

module net_conf_control (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                net_start,
  input  wire [cgra_conf_pkg::QTD_W-1:0]     qtd_net_conf,
  input  wire                                net_available_read,
  output logic                               net_req_rd_data,
  input  wire [cgra_conf_pkg::LINE_W-1:0]    net_rd_data,
  input  wire                                net_rd_data_valid,
  output logic                               push,
  output cgra_conf_pkg::net_conf_word_t      word,
  input  wire                                full,
  output logic                               done
);

  localparam int SLOT_CNT_W = $clog2(cgra_conf_pkg::NET_WORDS_PER_LINE);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA,
    ST_SEND,
    ST_DONE
  } state_t;

  state_t state;
  logic [cgra_conf_pkg::LINE_W-1:0] line;
  logic [cgra_conf_pkg::QTD_W-1:0] sent_cnt;
  logic [SLOT_CNT_W-1:0] slot_cnt;
  logic last_slot;
  logic last_word;

  assign net_req_rd_data = (state == ST_REQUEST) && net_available_read;
  assign push = (state == ST_SEND) && !full;
  assign done = (state == ST_DONE);

  assign last_slot = (slot_cnt == SLOT_CNT_W'(cgra_conf_pkg::NET_WORDS_PER_LINE - 1));
  assign last_word = (sent_cnt == qtd_net_conf - 1'b1);  // Count is held steady.

  always_comb begin
    word = line[cgra_conf_pkg::NET_SLOT_W-1:0];
  end

  // ------------------------------------------------------------------
  // Request and unpack cycle, 16 slots per line.
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      sent_cnt <= '0;
      slot_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (net_start) begin
            sent_cnt <= '0;
            // Empty network section needs no read at all.
            state <= (qtd_net_conf == '0) ? ST_DONE : ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (net_available_read) begin
            state <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA: begin
          if (net_rd_data_valid) begin
            line <= net_rd_data;
            slot_cnt <= '0;
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (!full) begin
            line <= line >> cgra_conf_pkg::NET_SLOT_W;
            sent_cnt <= sent_cnt + 1'b1;
            slot_cnt <= slot_cnt + 1'b1;
            if (last_word) begin
              state <= ST_DONE;
            end else if (last_slot) begin
              state <= ST_REQUEST;
            end
          end
        end
        ST_DONE: begin
          state <= ST_DONE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/conf_bus_merge.sv
`timescale 1ns/1ns
`default_nettype none

module conf_bus_merge #(
  parameter int CREDITS = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         pe_push,
  input  wire cgra_conf_pkg::pe_conf_word_t           pe_word,
  output logic                                        pe_full,
  input  wire                                         pe_done,
  input  wire                                         net_push,
  input  wire cgra_conf_pkg::net_conf_word_t          net_word,
  output logic                                        net_full,
  input  wire                                         net_done,
  output logic                                        conf_valid,
  output cgra_conf_pkg::conf_sel_t                    conf_sel,
  output logic [cgra_conf_pkg::CONF_PAYLOAD_W-1:0]    conf_payload,
  input  wire                                         credit_return,
  output logic                                        done
);

  localparam int CRED_W = $clog2(CREDITS + 1);
  localparam int NET_PAD =
    cgra_conf_pkg::CONF_PAYLOAD_W - $bits(cgra_conf_pkg::net_conf_word_t);

  cgra_conf_pkg::pe_conf_word_t pe_head;
  cgra_conf_pkg::net_conf_word_t net_head;
  cgra_conf_pkg::conf_sel_t last_sel;
  logic pe_empty;
  logic net_empty;
  logic pe_pop;
  logic net_pop;
  logic issue;
  logic grant_net;
  logic [CRED_W-1:0] credit_cnt;

  conf_word_fifo #(
    .payload_t(cgra_conf_pkg::pe_conf_word_t),
    .DEPTH(FIFO_DEPTH)
  ) u_pe_fifo (
    .clk(clk),
    .rst(rst),
    .push(pe_push),
    .push_data(pe_word),
    .full(pe_full),
    .pop(pe_pop),
    .pop_data(pe_head),
    .empty(pe_empty)
  );

  conf_word_fifo #(
    .payload_t(cgra_conf_pkg::net_conf_word_t),
    .DEPTH(FIFO_DEPTH)
  ) u_net_fifo (
    .clk(clk),
    .rst(rst),
    .push(net_push),
    .push_data(net_word),
    .full(net_full),
    .pop(net_pop),
    .pop_data(net_head),
    .empty(net_empty)
  );

  // ------------------------------------------------------------------
  // Round robin, gated by the credit counter.
  // ------------------------------------------------------------------
  always_comb begin
    if (!pe_empty && !net_empty) begin
      grant_net = (last_sel == cgra_conf_pkg::SEL_PE);
    end else begin
      grant_net = !net_empty;
    end
  end

  assign issue = (credit_cnt != '0) && !(pe_empty && net_empty);
  assign pe_pop = issue && !grant_net;
  assign net_pop = issue && grant_net;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CRED_W'(CREDITS);
      last_sel <= cgra_conf_pkg::SEL_NET;  // PE wins the first tie.
      conf_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt - CRED_W'(issue) + CRED_W'(credit_return);
      conf_valid <= issue;
      if (issue) begin
        last_sel <= grant_net ? cgra_conf_pkg::SEL_NET : cgra_conf_pkg::SEL_PE;
      end
      if (pe_done && net_done && pe_empty && net_empty) begin
        done <= 1'b1;  // Held until reset.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      conf_sel <= grant_net ? cgra_conf_pkg::SEL_NET : cgra_conf_pkg::SEL_PE;
      conf_payload <= grant_net ? {{NET_PAD{1'b0}}, net_head} : pe_head;
    end
  end

  // The array never returns more credits than it was given.
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CRED_W'(CREDITS));

endmodule

`default_nettype wire

//--- verilog/cgra_conf_loader.sv
`timescale 1ns/1ns
`default_nettype none

module cgra_conf_loader #(
  parameter int CREDITS = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         start,
  input  wire                                         pe_available_read,
  output logic                                        pe_req_rd_data,
  input  wire [cgra_conf_pkg::LINE_W-1:0]             pe_rd_data,
  input  wire                                         pe_rd_data_valid,
  input  wire                                         net_available_read,
  output logic                                        net_req_rd_data,
  input  wire [cgra_conf_pkg::LINE_W-1:0]             net_rd_data,
  input  wire                                         net_rd_data_valid,
  output logic                                        conf_valid,
  output cgra_conf_pkg::conf_sel_t                    conf_sel,
  output logic [cgra_conf_pkg::CONF_PAYLOAD_W-1:0]    conf_payload,
  input  wire                                         credit_return,
  output logic [1:0]                                  read_fifo_mask,
  output logic [1:0]                                  write_fifo_mask,
  output logic [cgra_conf_pkg::QTD_W-1:0]             qtd_net_conf,
  output logic                                        done
);

  cgra_conf_pkg::pe_conf_word_t pe_word;
  cgra_conf_pkg::net_conf_word_t net_word;
  logic pe_push;
  logic pe_full;
  logic pe_done;
  logic net_push;
  logic net_full;
  logic net_done;
  logic net_start;

  pe_conf_control u_pe_ctrl (
    .clk(clk),
    .rst(rst),
    .start(start),
    .pe_available_read(pe_available_read),
    .pe_req_rd_data(pe_req_rd_data),
    .pe_rd_data(pe_rd_data),
    .pe_rd_data_valid(pe_rd_data_valid),
    .push(pe_push),
    .word(pe_word),
    .full(pe_full),
    .qtd_net_conf(qtd_net_conf),
    .net_start(net_start),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .done(pe_done)
  );

  net_conf_control u_net_ctrl (
    .clk(clk),
    .rst(rst),
    .net_start(net_start),
    .qtd_net_conf(qtd_net_conf),
    .net_available_read(net_available_read),
    .net_req_rd_data(net_req_rd_data),
    .net_rd_data(net_rd_data),
    .net_rd_data_valid(net_rd_data_valid),
    .push(net_push),
    .word(net_word),
    .full(net_full),
    .done(net_done)
  );

  conf_bus_merge #(
    .CREDITS(CREDITS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_merge (
    .clk(clk),
    .rst(rst),
    .pe_push(pe_push),
    .pe_word(pe_word),
    .pe_full(pe_full),
    .pe_done(pe_done),
    .net_push(net_push),
    .net_word(net_word),
    .net_full(net_full),
    .net_done(net_done),
    .conf_valid(conf_valid),
    .conf_sel(conf_sel),
    .conf_payload(conf_payload),
    .credit_return(credit_return),
    .done(done)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- verification/tb_cgra_conf_loader.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cgra_conf_loader;

  localparam int CREDITS = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int MEM_LINES = 8;
  localparam int WAIT_LIMIT = 3000;

  logic clk;
  logic rst = 1'b1;
  logic start = 1'b0;
  logic pe_available_read = 1'b0;
  logic pe_req_rd_data;
  logic [cgra_conf_pkg::LINE_W-1:0] pe_rd_data = '0;
  logic pe_rd_data_valid = 1'b0;
  logic net_available_read = 1'b0;
  logic net_req_rd_data;
  logic [cgra_conf_pkg::LINE_W-1:0] net_rd_data = '0;
  logic net_rd_data_valid = 1'b0;
  logic conf_valid;
  cgra_conf_pkg::conf_sel_t conf_sel;
  logic [cgra_conf_pkg::CONF_PAYLOAD_W-1:0] conf_payload;
  logic credit_return = 1'b0;
  logic [1:0] read_fifo_mask;
  logic [1:0] write_fifo_mask;
  logic [31:0] qtd_net_conf;
  logic done;

  int seed = 32'h5bf5_e40c;
  logic stall = 1'b0;  // Array holds back all credits.
  int value_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;

  // Model state.
  int pe_idx, net_idx, pe_wait, net_wait;
  int owed, bus_words, returned, net_req_count;
  int pe_seen, net_seen;

  logic [cgra_conf_pkg::LINE_W-1:0] pe_mem [MEM_LINES];
  logic [cgra_conf_pkg::LINE_W-1:0] net_mem [MEM_LINES];
  cgra_conf_pkg::pe_conf_word_t exp_pe [$];
  cgra_conf_pkg::net_conf_word_t exp_net [$];

  tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

  cgra_conf_loader #(
    .CREDITS(CREDITS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .pe_available_read(pe_available_read),
    .pe_req_rd_data(pe_req_rd_data),
    .pe_rd_data(pe_rd_data),
    .pe_rd_data_valid(pe_rd_data_valid),
    .net_available_read(net_available_read),
    .net_req_rd_data(net_req_rd_data),
    .net_rd_data(net_rd_data),
    .net_rd_data_valid(net_rd_data_valid),
    .conf_valid(conf_valid),
    .conf_sel(conf_sel),
    .conf_payload(conf_payload),
    .credit_return(credit_return),
    .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask),
    .qtd_net_conf(qtd_net_conf),
    .done(done)
  );

  // ------------------------------------------------------------------
  // Reference model.
  // ------------------------------------------------------------------
  // PE word n sits in 64-bit slot n % 8 of the line after the header.
  function automatic cgra_conf_pkg::pe_conf_word_t ref_pe_word(input int n);
    logic [63:0] slot;
    cgra_conf_pkg::pe_conf_word_t w;
    slot = pe_mem[1 + n / cgra_conf_pkg::PE_WORDS_PER_LINE]
                 [(n % cgra_conf_pkg::PE_WORDS_PER_LINE) * 64 +: 64];
    w.op = slot[3:0];
    w.id = slot[31:16];
    w.data = {slot[15:8], slot[63:32]};
    return w;
  endfunction

  function automatic cgra_conf_pkg::net_conf_word_t ref_net_word(input int n);
    logic [31:0] slot;
    cgra_conf_pkg::net_conf_word_t w;
    slot = net_mem[n / cgra_conf_pkg::NET_WORDS_PER_LINE]
                  [(n % cgra_conf_pkg::NET_WORDS_PER_LINE) * 32 +: 32];
    w.switch_id = slot[15:0];
    w.route = slot[31:16];
    return w;
  endfunction

  task automatic build_lines(input int n_pe, input int n_net, input logic [1:0] rd_mask,
                             input logic [1:0] wr_mask);
    int l;
    int w;
    for (l = 0; l < MEM_LINES; l++) begin
      for (w = 0; w < cgra_conf_pkg::LINE_W / 32; w++) begin
        pe_mem[l][w*32 +: 32] = $random(seed);
        net_mem[l][w*32 +: 32] = $random(seed);
      end
    end
    pe_mem[0][31:0] = n_pe;  // Header line.
    pe_mem[0][63:32] = n_net;
    pe_mem[0][65:64] = rd_mask;
    pe_mem[0][97:96] = wr_mask;
  endtask

  task automatic build_expected(input int n_pe, input int n_net);
    int n;
    exp_pe.delete();
    exp_net.delete();
    for (n = 0; n < n_pe; n++) begin
      exp_pe.push_back(ref_pe_word(n));
    end
    for (n = 0; n < n_net; n++) begin
      exp_net.push_back(ref_net_word(n));
    end
  endtask

  // ------------------------------------------------------------------
  // Checks.
  // ------------------------------------------------------------------
  task automatic check_pe_word(input cgra_conf_pkg::pe_conf_word_t got,
                               input cgra_conf_pkg::pe_conf_word_t exp, input int idx);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR conf_payload (PE word %0d): got %h expected %h", idx, got, exp);
    end
  endtask

  task automatic check_net_word(input cgra_conf_pkg::net_conf_word_t got,
                                input cgra_conf_pkg::net_conf_word_t exp,
                                input logic [27:0] pad, input int idx);
    if (got !== exp || pad !== '0) begin
      value_errors++;
      $display("ERROR conf_payload (network word %0d): got %h expected %h",
               idx, {pad, got}, {28'h0, exp});
    end
  endtask

  task automatic check_header(input logic [1:0] rd_got, input logic [1:0] rd_exp,
                              input logic [1:0] wr_got, input logic [1:0] wr_exp,
                              input logic [31:0] qtd_got, input logic [31:0] qtd_exp);
    if (rd_got !== rd_exp) begin
      value_errors++;
      $display("ERROR read_fifo_mask: got %h expected %h", rd_got, rd_exp);
    end
    if (wr_got !== wr_exp) begin
      value_errors++;
      $display("ERROR write_fifo_mask: got %h expected %h", wr_got, wr_exp);
    end
    if (qtd_got !== qtd_exp) begin
      value_errors++;
      $display("ERROR qtd_net_conf: got %h expected %h", qtd_got, qtd_exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_bus_words(input int n, input int limit);
    int i;
    i = 0;
    while (bus_words < n && i < limit) begin
      @(posedge clk);
      i++;
    end
    if (bus_words < n) begin
      timeout_errors++;
      $display("Timeout: only %0d words reached the bus, waited for %0d", bus_words, n);
    end
  endtask

  task automatic wait_done(input int limit);
    int i;
    i = 0;
    while (done !== 1'b1 && i < limit) begin
      @(posedge clk);
      i++;
    end
    if (done !== 1'b1) begin
      timeout_errors++;
      $display("Timeout: done did not rise within %0d cycles", limit);
    end
  endtask

  // ------------------------------------------------------------------
  // One load from reset to done.
  // ------------------------------------------------------------------
  task automatic run_load(input int n_pe, input int n_net, input logic [1:0] rd_mask,
                          input logic [1:0] wr_mask);
    rst = 1'b1;
    start = 1'b0;
    @(posedge clk);
    #1;
    build_lines(n_pe, n_net, rd_mask, wr_mask);  // Models draw nothing in reset.
    build_expected(n_pe, n_net);
    @(posedge clk);
    #1 rst = 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_bit("pe_req_rd_data", pe_req_rd_data, 1'b0);
      check_bit("net_req_rd_data", net_req_rd_data, 1'b0);
      check_bit("conf_valid", conf_valid, 1'b0);
      check_bit("done", done, 1'b0);
      check_header(read_fifo_mask, 2'b00, write_fifo_mask, 2'b00, qtd_net_conf, 32'h0);
    end
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    if (n_net > 0) begin
      wait_bus_words(8, WAIT_LIMIT);
      if (timeout_errors != 0) return;
      #1 stall = 1'b1;
      repeat (60) @(posedge clk);
      #1 stall = 1'b0;
    end
    wait_done(WAIT_LIMIT);
    if (timeout_errors != 0) return;
    repeat (3) @(posedge clk);
    check_bit("done", done, 1'b1);
    check_header(read_fifo_mask, rd_mask, write_fifo_mask, wr_mask, qtd_net_conf, 32'(n_net));
    if (exp_pe.size() != 0) begin
      protocol_errors++;
      $display("%0d PE words never reached the bus", exp_pe.size());
    end
    if (exp_net.size() != 0) begin
      protocol_errors++;
      $display("%0d network words never reached the bus", exp_net.size());
    end
    if (n_net == 0 && net_req_count != 0) begin
      protocol_errors++;
      $display("Network port requested %0d lines with a zero network count", net_req_count);
    end
    #1;
  endtask

  initial begin
    run_load(20, 37, 2'b10, 2'b01);
    if (timeout_errors == 0) begin
      run_load(5, 0, 2'b01, 2'b11);
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // Memory models and credit-returning array.
  // ------------------------------------------------------------------
  always @(posedge clk) begin : models
    logic rst_s, stall_s, pe_req_s, net_req_s, valid_s, ret_s;
    rst_s = rst;
    stall_s = stall;
    pe_req_s = pe_req_rd_data;
    net_req_s = net_req_rd_data;
    valid_s = conf_valid;
    ret_s = credit_return;
    #1;
    pe_rd_data_valid = 1'b0;
    net_rd_data_valid = 1'b0;
    credit_return = 1'b0;
    if (rst_s) begin
      pe_idx = 0;
      net_idx = 0;
      pe_wait = 0;
      net_wait = 0;
      owed = 0;
      bus_words = 0;
      returned = 0;
      net_req_count = 0;
    end else begin
      if (valid_s) begin
        bus_words++;
        owed++;
      end
      if (bus_words - returned > CREDITS) begin
        protocol_errors++;
        $display("Bus holds %0d words without credit, limit is %0d",
                 bus_words - returned, CREDITS);
      end
      if (ret_s) begin
        returned++;
      end
      if (pe_req_s) begin
        if (pe_wait != 0) begin
          protocol_errors++;
          $display("PE port requested a line while one was outstanding");
        end
        pe_wait = 1 + ({$random(seed)} % 4);
      end else if (pe_wait != 0) begin
        pe_wait--;
        if (pe_wait == 0 && pe_idx >= MEM_LINES) begin
          protocol_errors++;
          $display("PE port read past the last memory line");
        end else if (pe_wait == 0) begin
          pe_rd_data = pe_mem[pe_idx];
          pe_rd_data_valid = 1'b1;
          pe_idx++;
        end
      end
      if (net_req_s) begin
        net_req_count++;
        if (net_wait != 0) begin
          protocol_errors++;
          $display("Network port requested a line while one was outstanding");
        end
        net_wait = 1 + ({$random(seed)} % 4);
      end else if (net_wait != 0) begin
        net_wait--;
        if (net_wait == 0 && net_idx >= MEM_LINES) begin
          protocol_errors++;
          $display("Network port read past the last memory line");
        end else if (net_wait == 0) begin
          net_rd_data = net_mem[net_idx];
          net_rd_data_valid = 1'b1;
          net_idx++;
        end
      end
      pe_available_read = ({$random(seed)} % 4) != 0;
      net_available_read = ({$random(seed)} % 4) != 0;
      if (!stall_s && owed > 0 && ({$random(seed)} % 3) == 0) begin
        credit_return = 1'b1;  // Array consumed one word.
        owed--;
      end
    end
  end

  // Bus words are matched against the queue of their own stream.
  always @(posedge clk) begin : compare
    cgra_conf_pkg::pe_conf_word_t pe_exp;
    cgra_conf_pkg::net_conf_word_t net_exp;
    if (rst) begin
      pe_seen = 0;
      net_seen = 0;
    end else if (conf_valid) begin
      if (conf_sel == cgra_conf_pkg::SEL_PE && exp_pe.size() == 0) begin
        protocol_errors++;
        $display("Extra PE word on the configuration bus");
      end else if (conf_sel == cgra_conf_pkg::SEL_PE) begin
        pe_exp = exp_pe.pop_front();
        check_pe_word(cgra_conf_pkg::pe_conf_word_t'(conf_payload), pe_exp, pe_seen);
        pe_seen++;
      end else if (exp_net.size() == 0) begin
        protocol_errors++;
        $display("Extra network word on the configuration bus");
      end else begin
        net_exp = exp_net.pop_front();
        check_net_word(cgra_conf_pkg::net_conf_word_t'(conf_payload[31:0]), net_exp,
                       conf_payload[59:32], net_seen);
        net_seen++;
      end
    end
  end

endmodule

`default_nettype wire

//--- src.f
verilog/cgra_conf_pkg.sv
verilog/conf_word_fifo.sv
verilog/pe_conf_control.sv
verilog/net_conf_control.sv
verilog/conf_bus_merge.sv
verilog/cgra_conf_loader.sv
verification/tb_clock.sv
verification/tb_cgra_conf_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the configuration loader testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cgra_conf_loader \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
